// File: src/scurve_pkg.sv
`default_nettype none

package scurve_pkg;

    ////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////

    // Channel number on the ASIC, 64 channels
    typedef logic [5:0]   chn_t;
    // Threshold DAC code
    typedef logic [9:0]   dac_t;
    // Hit counts and window length
    typedef logic [15:0]  cnt_t;
    // One USB data FIFO word
    typedef logic [15:0]  word_t;
    // Three discriminator bits per channel
    typedef logic [191:0] mask_t;
    // Test-charge injection, one bit per channel
    typedef logic [63:0]  ctest_t;

    // Highest channel of a full sweep
    localparam chn_t CHN_LAST = chn_t'(63);

    ////////////////////////////////////////////////////////////
    // Frame markers in the USB stream
    ////////////////////////////////////////////////////////////

    // "SC", opens a sweep
    localparam word_t FRAME_START = 16'h5343;
    // "ED", closes a sweep
    localparam word_t FRAME_END   = 16'h4544;

    // Sequencer states
    typedef enum logic [3:0] {
        IDLE,
        HEADER,
        LOAD,
        WAIT_CFG,
        COUNT,
        EMIT_POINT,
        EMIT_COUNT,
        NEXT,
        TRAILER
    } sweep_state_t;

endpackage

`default_nettype wire

// File: src/scurve_fifo_if.sv
`default_nettype none

// Count-word stream, counter -> FIFO -> sequencer
interface scurve_fifo_if;
    import scurve_pkg::*;

    word_t wdata;
    logic  wr_en;
    word_t rdata;
    logic  rd_en;
    logic  empty;
    logic  full;

    // Hit counter side
    modport writer (output wdata, output wr_en, input full);

    // Storage itself
    modport fifo (input wdata, input wr_en, input rd_en,
                  output rdata, output empty, output full);

    // Sequencer side, word shown ahead of rd_en
    modport reader (input rdata, input empty, output rd_en);

endinterface

`default_nettype wire

// File: src/scurve_sweep_control.sv
`default_nettype none

module scurve_sweep_control #(
    parameter int DAC_FIRST = 0,
    parameter int DAC_LAST  = 1023,
    parameter int DAC_STEP  = 1
) (
    input  logic               Clk,
    input  logic               reset_n,
    input  logic               test_start,
    input  scurve_pkg::chn_t   single_chn,
    input  logic               single_mode,
    input  logic               ctest_mode,
    input  logic               config_done,
    output logic               sc_load,
    output scurve_pkg::ctest_t ctest_chn,
    output scurve_pkg::dac_t   dac_code,
    output scurve_pkg::mask_t  disc_mask,
    output logic               count_start,
    input  logic               count_done,
    output logic               flush,
    scurve_fifo_if.reader      data,
    output logic               usb_wr_en,
    output scurve_pkg::word_t  usb_wr_data,
    output logic               test_done
);
    import scurve_pkg::*;

    ////////////////////////////////////////////////////////////
    // Start request and config-done edges
    ////////////////////////////////////////////////////////////

    logic start_q1;
    logic start_q2;
    logic start_pulse;
    logic cfg_q;
    logic cfg_rise;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            start_q1 <= 1'b0;
            start_q2 <= 1'b0;
            cfg_q    <= 1'b0;
        end else begin
            start_q1 <= test_start;
            start_q2 <= start_q1;
            cfg_q    <= config_done;
        end
    end

    assign start_pulse = start_q1 & ~start_q2;
    // Config engine drops done on load, so wait for a fresh rise
    assign cfg_rise    = config_done & ~cfg_q;

    // One channel enabled, all three discriminators
    function automatic mask_t chn_mask(input chn_t chn);
        mask_t m;
        m = '0;
        m[3 * chn +: 3] = 3'b111;
        return m;
    endfunction

    ////////////////////////////////////////////////////////////
    // Sweep FSM
    ////////////////////////////////////////////////////////////

    sweep_state_t state;
    chn_t         chn_cur;
    dac_t         dac_cur;
    logic         run_single;
    logic         run_ctest;
    logic         last_dac;
    logic         last_chn;

    // Compare in int so a step past 1023 does not wrap
    assign last_dac = (int'(dac_cur) + DAC_STEP) > DAC_LAST;
    assign last_chn = run_single || (chn_cur == CHN_LAST);

    // Count word is shown by the FIFO, popped as it goes out
    assign data.rd_en = (state == EMIT_COUNT) && !data.empty;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= IDLE;
            chn_cur     <= '0;
            dac_cur     <= '0;
            run_single  <= 1'b0;
            run_ctest   <= 1'b0;
            sc_load     <= 1'b0;
            count_start <= 1'b0;
            flush       <= 1'b0;
            usb_wr_en   <= 1'b0;
            test_done   <= 1'b0;
            ctest_chn   <= '0;
            dac_code    <= '0;
            disc_mask   <= '0;
        end else begin
            // Single-cycle strobes
            sc_load     <= 1'b0;
            count_start <= 1'b0;
            flush       <= 1'b0;
            usb_wr_en   <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_pulse) begin
                        // Mode inputs held for the whole sweep
                        flush      <= 1'b1;
                        test_done  <= 1'b0;
                        run_single <= single_mode;
                        run_ctest  <= ctest_mode;
                        chn_cur    <= single_mode ? single_chn : '0;
                        dac_cur    <= dac_t'(DAC_FIRST);
                        state      <= HEADER;
                    end
                end
                HEADER: begin
                    usb_wr_en <= 1'b1;
                    state     <= LOAD;
                end
                LOAD: begin
                    // New point goes out with the load strobe
                    dac_code  <= dac_cur;
                    disc_mask <= chn_mask(chn_cur);
                    ctest_chn <= run_ctest ? (ctest_t'(1) << chn_cur) : '0;
                    sc_load   <= 1'b1;
                    state     <= WAIT_CFG;
                end
                WAIT_CFG: begin
                    if (cfg_rise) begin
                        count_start <= 1'b1;
                        state       <= COUNT;
                    end
                end
                COUNT: begin
                    // Word already in the FIFO when done arrives
                    if (count_done) begin
                        state <= EMIT_POINT;
                    end
                end
                EMIT_POINT: begin
                    usb_wr_en <= 1'b1;
                    state     <= EMIT_COUNT;
                end
                EMIT_COUNT: begin
                    if (!data.empty) begin
                        usb_wr_en <= 1'b1;
                        state     <= NEXT;
                    end
                end
                NEXT: begin
                    if (!last_dac) begin
                        dac_cur <= dac_t'(int'(dac_cur) + DAC_STEP);
                        state   <= LOAD;
                    end else if (!last_chn) begin
                        chn_cur <= chn_cur + chn_t'(1);
                        dac_cur <= dac_t'(DAC_FIRST);
                        state   <= LOAD;
                    end else begin
                        state <= TRAILER;
                    end
                end
                TRAILER: begin
                    usb_wr_en <= 1'b1;
                    test_done <= 1'b1;
                    state     <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // USB word, qualified by usb_wr_en
    always_ff @(posedge Clk) begin
        case (state)
            HEADER:     usb_wr_data <= FRAME_START;
            EMIT_POINT: usb_wr_data <= {chn_cur, dac_cur};
            EMIT_COUNT: usb_wr_data <= data.rdata;
            TRAILER:    usb_wr_data <= FRAME_END;
            default:    usb_wr_data <= usb_wr_data;
        endcase
    end

endmodule

`default_nettype wire

// File: src/scurve_hit_counter.sv
`default_nettype none

module scurve_hit_counter (
    input  logic             Clk,
    input  logic             reset_n,
    input  logic             ext_clk,
    input  logic             trigger0_n,
    input  logic             trigger1_n,
    input  logic             trigger2_n,
    input  scurve_pkg::cnt_t cpt_max,
    input  logic             count_start,
    output logic             count_done,
    scurve_fifo_if.writer    data
);
    import scurve_pkg::*;

    ////////////////////////////////////////////////////////////
    // Pin synchronizers
    ////////////////////////////////////////////////////////////

    // Two sync stages plus one for edge detect
    logic [2:0] ext_clk_sync;
    // Triggers as {2, 1, 0}
    logic [2:0] trig_sync1;
    logic [2:0] trig_sync2;
    logic       ext_rise;
    logic       hit;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            ext_clk_sync <= '0;
            trig_sync1   <= 3'b111;
            trig_sync2   <= 3'b111;
        end else begin
            ext_clk_sync <= {ext_clk_sync[1:0], ext_clk};
            trig_sync1   <= {trigger2_n, trigger1_n, trigger0_n};
            trig_sync2   <= trig_sync1;
        end
    end

    assign ext_rise = ext_clk_sync[1] & ~ext_clk_sync[2];
    // Active low, any one of the three counts
    assign hit      = ~&trig_sync2;

    ////////////////////////////////////////////////////////////
    // Count window
    ////////////////////////////////////////////////////////////

    logic  active;
    cnt_t  edge_cnt;
    cnt_t  hit_cnt;
    cnt_t  hit_sum;
    logic  last_edge;
    logic  wr_q;
    cnt_t  count_word;

    // Includes a hit on the current edge
    assign hit_sum   = hit_cnt + cnt_t'(hit);
    assign last_edge = ({1'b0, edge_cnt} + 17'd1) >= {1'b0, cpt_max};

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            active     <= 1'b0;
            edge_cnt   <= '0;
            hit_cnt    <= '0;
            wr_q       <= 1'b0;
            count_done <= 1'b0;
        end else begin
            wr_q <= 1'b0;
            // Done one cycle after the write, word is stored by then
            count_done <= wr_q;
            if (count_start) begin
                active   <= 1'b1;
                edge_cnt <= '0;
                hit_cnt  <= '0;
            end else if (active && ext_rise) begin
                edge_cnt <= edge_cnt + cnt_t'(1);
                hit_cnt  <= hit_sum;
                if (last_edge) begin
                    active <= 1'b0;
                    wr_q   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (active && ext_rise && last_edge) begin
            count_word <= hit_sum;
        end
    end

    // Full is not expected, one word per point
    assign data.wr_en = wr_q & ~data.full;
    assign data.wdata = word_t'(count_word);

endmodule

`default_nettype wire

// File: src/scurve_data_fifo.sv
`default_nettype none

module scurve_data_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        Clk,
    input  logic        reset_n,
    input  logic        flush,
    scurve_fifo_if.fifo data
);
    import scurve_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // Storage
    word_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] level;
    logic             do_wr;
    logic             do_rd;

    assign data.empty = (level == '0);
    assign data.full  = (level == CNT_W'(FIFO_DEPTH));
    assign do_wr      = data.wr_en & ~data.full;
    assign do_rd      = data.rd_en & ~data.empty;

    // Fall-through, head word always on rdata
    assign data.rdata = mem[rd_ptr];

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + PTR_W'(1);
    endfunction

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (flush) begin
            // Drop anything left from the last sweep
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   level <= level + CNT_W'(1);
                2'b01:   level <= level - CNT_W'(1);
                default: level <= level;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data.wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/scurve_test_top.sv
`default_nettype none

module scurve_test_top #(
    parameter int DAC_FIRST  = 0,
    parameter int DAC_LAST   = 1023,
    parameter int DAC_STEP   = 1,
    parameter int FIFO_DEPTH = 16
) (
    input  logic               Clk,
    input  logic               reset_n,
    // Test request and parameters
    input  logic               test_start,
    input  scurve_pkg::chn_t   single_chn,
    input  logic               single_mode,
    input  logic               ctest_mode,
    input  scurve_pkg::cnt_t   cpt_max,
    // Slow-control side
    input  logic               config_done,
    output logic               sc_load,
    output scurve_pkg::ctest_t ctest_chn,
    output scurve_pkg::dac_t   dac_code,
    output scurve_pkg::mask_t  disc_mask,
    // ASIC pins
    input  logic               ext_clk,
    input  logic               trigger0_n,
    input  logic               trigger1_n,
    input  logic               trigger2_n,
    // USB data FIFO write port
    output logic               usb_wr_en,
    output scurve_pkg::word_t  usb_wr_data,
    output logic               test_done
);

    ////////////////////////////////////////////////////////////
    // Internal links
    ////////////////////////////////////////////////////////////

    logic count_start;
    logic count_done;
    logic flush;

    // Count words, counter to sequencer
    scurve_fifo_if count_fifo ();

    scurve_sweep_control #(
        .DAC_FIRST (DAC_FIRST),
        .DAC_LAST  (DAC_LAST),
        .DAC_STEP  (DAC_STEP)
    ) sweep_control_i (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .test_start  (test_start),
        .single_chn  (single_chn),
        .single_mode (single_mode),
        .ctest_mode  (ctest_mode),
        .config_done (config_done),
        .sc_load     (sc_load),
        .ctest_chn   (ctest_chn),
        .dac_code    (dac_code),
        .disc_mask   (disc_mask),
        .count_start (count_start),
        .count_done  (count_done),
        .flush       (flush),
        .data        (count_fifo.reader),
        .usb_wr_en   (usb_wr_en),
        .usb_wr_data (usb_wr_data),
        .test_done   (test_done)
    );

    scurve_hit_counter hit_counter_i (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .ext_clk     (ext_clk),
        .trigger0_n  (trigger0_n),
        .trigger1_n  (trigger1_n),
        .trigger2_n  (trigger2_n),
        .cpt_max     (cpt_max),
        .count_start (count_start),
        .count_done  (count_done),
        .data        (count_fifo.writer)
    );

    scurve_data_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) data_fifo_i (
        .Clk     (Clk),
        .reset_n (reset_n),
        .flush   (flush),
        .data    (count_fifo.fifo)
    );

endmodule

`default_nettype wire

// File: bench/scurve_checker.sv
`default_nettype none

module scurve_checker #(
    parameter int DAC_FIRST = 0,
    parameter int DAC_LAST  = 60,
    parameter int DAC_STEP  = 4
) (
    input  logic               Clk,
    input  logic               reset_n,
    // Test setup, as driven into the DUT
    input  logic               test_start,
    input  logic               single_mode,
    input  scurve_pkg::chn_t   single_chn,
    input  logic               ctest_mode,
    input  scurve_pkg::cnt_t   cpt_max,
    input  scurve_pkg::dac_t   thr [64],
    // DUT outputs
    input  logic               sc_load,
    input  scurve_pkg::ctest_t ctest_chn,
    input  scurve_pkg::dac_t   dac_code,
    input  scurve_pkg::mask_t  disc_mask,
    input  logic               usb_wr_en,
    input  scurve_pkg::word_t  usb_wr_data,
    input  logic               test_done,
    // Results for the testbench top
    output int                 err_cnt,
    output int                 word_cnt,
    output int                 pending
);
    timeunit 1ns;
    timeprecision 1ps;
    import scurve_pkg::*;

    // Predicted USB stream and predicted sweep points
    word_t  exp_words [$];
    chn_t   exp_chn [$];
    dac_t   exp_dac [$];

    logic   start_q;
    logic   started;
    logic   run_ctest;
    word_t  exp_w;
    chn_t   cur_chn;
    dac_t   cur_dac;
    ctest_t exp_ctest;

    // Mask model, bit b belongs to channel b/3
    function automatic mask_t expected_mask(input chn_t chn);
        mask_t m;
        for (int b = 0; b < 192; b++) begin
            m[b] = ((b / 3) == int'(chn));
        end
        return m;
    endfunction

    // Test-charge model, one bit per channel
    function automatic ctest_t expected_ctest(input chn_t chn, input logic charge_on);
        ctest_t v;
        for (int i = 0; i < 64; i++) begin
            v[i] = charge_on && (i == int'(chn));
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        err_cnt++;
        $display("ERROR at %0t: %0s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // Stream model, built at each start
    ////////////////////////////////////////////////////////////

    task automatic build_expected();
        int first_chn;
        int last_chn;
        first_chn = single_mode ? int'(single_chn) : 0;
        last_chn  = single_mode ? int'(single_chn) : 63;
        exp_words.delete();
        exp_chn.delete();
        exp_dac.delete();
        exp_words.push_back(FRAME_START);
        for (int c = first_chn; c <= last_chn; c++) begin
            for (int d = DAC_FIRST; d <= DAC_LAST; d += DAC_STEP) begin
                exp_chn.push_back(chn_t'(c));
                exp_dac.push_back(dac_t'(d));
                // Point word then hit count
                exp_words.push_back({chn_t'(c), dac_t'(d)});
                if (dac_t'(d) >= thr[c[5:0]]) begin
                    exp_words.push_back(word_t'(cpt_max));
                end else begin
                    exp_words.push_back(word_t'(0));
                end
            end
        end
        exp_words.push_back(FRAME_END);
    endtask

    ////////////////////////////////////////////////////////////
    // Port monitor
    ////////////////////////////////////////////////////////////

    always @(posedge Clk) begin
        if (!reset_n) begin
            start_q  = 1'b0;
            started  = 1'b0;
            err_cnt  = 0;
            word_cnt = 0;
            pending  = 0;
        end else begin
            if (test_start && !start_q) begin
                run_ctest = ctest_mode;
                build_expected();
                word_cnt  = 0;
                started   = 1'b1;
            end else if (!started && ((usb_wr_en !== 1'b0) || (sc_load !== 1'b0)
                                      || (test_done !== 1'b0))) begin
                report_error("DUT output active before the first start");
            end
            // USB stream against the model
            if (usb_wr_en) begin
                word_cnt++;
                if (exp_words.size() == 0) begin
                    report_error($sformatf("USB word %h written with none expected",
                                           usb_wr_data));
                end else begin
                    exp_w = exp_words.pop_front();
                    if (usb_wr_data !== exp_w) begin
                        report_error($sformatf("USB word %0d is %h, expected %h",
                                               word_cnt, usb_wr_data, exp_w));
                    end
                end
            end
            // Point setup on the load strobe
            if (sc_load) begin
                if (exp_chn.size() == 0) begin
                    report_error("slow-control load with no sweep point left");
                end else begin
                    cur_chn   = exp_chn.pop_front();
                    cur_dac   = exp_dac.pop_front();
                    exp_ctest = expected_ctest(cur_chn, run_ctest);
                    if (dac_code !== cur_dac) begin
                        report_error($sformatf("dac_code %0d, expected %0d",
                                               dac_code, cur_dac));
                    end
                    if (disc_mask !== expected_mask(cur_chn)) begin
                        report_error($sformatf("disc_mask wrong for channel %0d",
                                               cur_chn));
                    end
                    if (ctest_chn !== exp_ctest) begin
                        report_error($sformatf("ctest_chn %h, expected %h",
                                               ctest_chn, exp_ctest));
                    end
                end
            end
            pending = exp_words.size() + exp_chn.size();
            start_q = test_start;
        end
    end

endmodule

`default_nettype wire

// File: bench/scurve_tb.sv
`default_nettype none

module scurve_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import scurve_pkg::*;

    localparam int DAC_FIRST = 0;
    localparam int DAC_LAST  = 60;
    localparam int DAC_STEP  = 4;
    localparam int N_STEPS   = (DAC_LAST - DAC_FIRST) / DAC_STEP + 1;
    // Full 64-channel sweep needs about 120k cycles
    localparam int TIMEOUT   = 400000;

    logic   Clk;
    logic   reset_n;
    logic   test_start;
    chn_t   single_chn;
    logic   single_mode;
    logic   ctest_mode;
    cnt_t   cpt_max;
    logic   config_done = 1'b0;
    logic   ext_clk = 1'b0;
    logic   trigger0_n = 1'b1;
    logic   trigger1_n = 1'b1;
    logic   trigger2_n = 1'b1;
    logic   sc_load;
    ctest_t ctest_chn;
    dac_t   dac_code;
    mask_t  disc_mask;
    logic   usb_wr_en;
    word_t  usb_wr_data;
    logic   test_done;

    // Per-channel S-curve threshold of the ASIC model
    dac_t   thr [64];
    integer seed = 32'he5145e5b;
    int     cfg_wait = 0;
    int     ext_div = 2;
    int     tests_run = 0;
    int     tests_failed = 0;
    logic   timed_out = 1'b0;
    int     err_cnt;
    int     word_cnt;
    int     pending;

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    scurve_test_top #(
        .DAC_FIRST  (DAC_FIRST),
        .DAC_LAST   (DAC_LAST),
        .DAC_STEP   (DAC_STEP),
        .FIFO_DEPTH (16)
    ) scurve_test_top_i (
        .Clk (Clk), .reset_n (reset_n), .test_start (test_start),
        .single_chn (single_chn), .single_mode (single_mode), .ctest_mode (ctest_mode),
        .cpt_max (cpt_max), .config_done (config_done), .sc_load (sc_load),
        .ctest_chn (ctest_chn), .dac_code (dac_code), .disc_mask (disc_mask),
        .ext_clk (ext_clk), .trigger0_n (trigger0_n), .trigger1_n (trigger1_n),
        .trigger2_n (trigger2_n), .usb_wr_en (usb_wr_en), .usb_wr_data (usb_wr_data),
        .test_done (test_done)
    );

    scurve_checker #(
        .DAC_FIRST (DAC_FIRST),
        .DAC_LAST  (DAC_LAST),
        .DAC_STEP  (DAC_STEP)
    ) checker_i (
        .Clk (Clk), .reset_n (reset_n), .test_start (test_start),
        .single_mode (single_mode), .single_chn (single_chn), .ctest_mode (ctest_mode),
        .cpt_max (cpt_max), .thr (thr), .sc_load (sc_load), .ctest_chn (ctest_chn),
        .dac_code (dac_code), .disc_mask (disc_mask), .usb_wr_en (usb_wr_en),
        .usb_wr_data (usb_wr_data), .test_done (test_done),
        .err_cnt (err_cnt), .word_cnt (word_cnt), .pending (pending)
    );

    ////////////////////////////////////////////////////////////
    // ASIC and slow-control models
    ////////////////////////////////////////////////////////////

    // Enabled channel fires while the DAC is at or above its threshold
    function automatic logic discriminator_fires(input mask_t m, input dac_t dac);
        logic fires;
        fires = 1'b0;
        for (int i = 0; i < 64; i++) begin
            if (m[3 * i] && (dac >= thr[i])) begin
                fires = 1'b1;
            end
        end
        return fires;
    endfunction

    always @(posedge Clk) begin
        trigger0_n <= !discriminator_fires(disc_mask, dac_code);
        trigger1_n <= !discriminator_fires(disc_mask, dac_code);
        trigger2_n <= !discriminator_fires(disc_mask, dac_code);
    end

    // External clock, toggles every 2 or 3 cycles
    always @(posedge Clk) begin
        if (ext_div <= 1) begin
            ext_clk <= ~ext_clk;
            ext_div <= 2 + int'($unsigned($random(seed)) % 2);
        end else begin
            ext_div <= ext_div - 1;
        end
    end

    // Config engine, done drops on load and returns 1 to 6 cycles later
    always @(posedge Clk) begin
        if (sc_load) begin
            config_done <= 1'b0;
            cfg_wait    <= 1 + int'($unsigned($random(seed)) % 6);
        end else if (cfg_wait == 1) begin
            config_done <= 1'b1;
            cfg_wait    <= 0;
        end else if (cfg_wait > 1) begin
            cfg_wait <= cfg_wait - 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    task automatic check_idle();
        int errs_before;
        errs_before = err_cnt;
        repeat (30) @(negedge Clk);
        tests_run++;
        if (err_cnt != errs_before) begin
            tests_failed++;
            $display("test idle after reset: failed");
        end else begin
            $display("test idle after reset: passed");
        end
    endtask

    task automatic run_sweep(input string name, input logic single, input chn_t chn,
                             input logic ctest);
        int   errs_before;
        int   exp_words;
        int   waited;
        logic ok;
        if (timed_out) begin
            return;
        end
        errs_before = err_cnt;
        exp_words   = 2 + 2 * (single ? 1 : 64) * N_STEPS;
        ok          = 1'b1;
        @(posedge Clk);
        single_mode <= single;
        single_chn  <= chn;
        ctest_mode  <= ctest;
        cpt_max     <= cnt_t'(4 + $unsigned($random(seed)) % 17);
        @(posedge Clk);
        test_start <= 1'b1;
        // Held past the start pulse, two cycles after the edge
        repeat (4) @(posedge Clk);
        test_start <= 1'b0;
        waited = 0;
        while ((test_done !== 1'b1) && (waited < TIMEOUT)) begin
            @(negedge Clk);
            waited++;
        end
        if (test_done !== 1'b1) begin
            $display("test %0s: test_done did not rise within %0d cycles", name, TIMEOUT);
            timed_out = 1'b1;
            ok        = 1'b0;
        end else begin
            // Let the checker take in FRAME_END
            repeat (3) @(negedge Clk);
            if (word_cnt != exp_words) begin
                $display("ERROR at %0t: %0d words written, expected %0d",
                         $time, word_cnt, exp_words);
                ok = 1'b0;
            end
            if (pending != 0) begin
                $display("test %0s: %0d predicted items never appeared", name, pending);
                ok = 1'b0;
            end
        end
        if (err_cnt != errs_before) begin
            ok = 1'b0;
        end
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %0s: %0s", name, ok ? "passed" : "failed");
    endtask

    initial begin
        reset_n     = 1'b0;
        test_start  = 1'b0;
        single_chn  = '0;
        single_mode = 1'b0;
        ctest_mode  = 1'b0;
        cpt_max     = cnt_t'(8);
        for (int i = 0; i < 64; i++) begin
            thr[i] = dac_t'($unsigned($random(seed)) % 72);
        end
        repeat (8) @(posedge Clk);
        reset_n <= 1'b1;

        check_idle();
        run_sweep("single channel with test charge", 1'b1,
                  chn_t'($unsigned($random(seed)) % 64), 1'b1);
        run_sweep("single channel without test charge", 1'b1,
                  chn_t'($unsigned($random(seed)) % 64), 1'b0);
        run_sweep("all 64 channels", 1'b0, chn_t'(0), 1'b1);
        run_sweep("restart after done", 1'b1,
                  chn_t'($unsigned($random(seed)) % 64), 1'b1);

        $display("tests run %0d, failed %0d, checker errors %0d",
                 tests_run, tests_failed, err_cnt);
        if ((tests_failed == 0) && (err_cnt == 0) && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: scurve_test.f
src/scurve_pkg.sv
src/scurve_fifo_if.sv
src/scurve_sweep_control.sv
src/scurve_hit_counter.sv
src/scurve_data_fifo.sv
src/scurve_test_top.sv
bench/scurve_checker.sv
bench/scurve_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the S-curve sequencer simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module scurve_tb \
    -f scurve_test.f

./obj_dir/Vscurve_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
exit 0
